// ==== build.f ====
csrPkg.sv
csrFile.sv
csrArbiter.sv
csrInstrPort.sv
csrAxiLiteSlave.sv
csrSubsystem.sv
csrSubsystemTb.sv

// ==== csrArbiter.sv ====
module csrArbiter import csrPkg::*; (
    input  logic   clk,
    input  logic   arstN,
    input  logic   valid0,
    input  csrId   id0,
    input  csrOp   op0,
    input  logic   write0,
    input  csrData data0,
    input  logic   valid1,
    input  csrId   id1,
    input  csrOp   op1,
    input  logic   write1,
    input  csrData data1,
    input  csrData accRdata,
    output logic   grant0,
    output logic   grant1,
    output csrData rdata,
    output logic   accValid,
    output csrId   accId,
    output csrOp   accOp,
    output logic   accWrite,
    output csrData accData
);

    // high when requester 1 had the port last
    logic lastServed;
    logic pick1;

    // requester 1 wins when alone or when requester 0 went last
    assign pick1 = valid1 && (!valid0 || !lastServed);

    assign grant1 = pick1;
    assign grant0 = valid0 && !pick1;

    assign accValid = valid0 || valid1;
    assign accId    = pick1 ? id1    : id0;
    assign accOp    = pick1 ? op1    : op0;
    assign accWrite = pick1 ? write1 : write0;
    assign accData  = pick1 ? data1  : data0;

    // old value goes back to whichever side holds the grant
    assign rdata = accRdata;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            lastServed <= 1'b1;
        end else if (accValid) begin
            lastServed <= pick1;
        end
    end

endmodule

// ==== csrAxiLiteSlave.sv ====
module csrAxiLiteSlave import csrPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    // write address and data
    input  logic       awvalid,
    output logic       awready,
    input  axiAddr     awaddr,
    input  logic       wvalid,
    output logic       wready,
    input  csrData     wdata,
    input  logic [7:0] wstrb,
    // write response
    output logic       bvalid,
    input  logic       bready,
    output logic [1:0] bresp,
    // read address and data
    input  logic       arvalid,
    output logic       arready,
    input  axiAddr     araddr,
    output logic       rvalid,
    input  logic       rready,
    output csrData     rdata,
    output logic [1:0] rresp,
    // arbiter side
    input  logic       grant,
    input  csrData     readData,
    output logic       reqValid,
    output csrId       reqId,
    output csrOp       reqOp,
    output logic       reqWrite,
    output csrData     reqData
);

    axiState state;
    csrData  readQ;
    logic    idle;
    logic    wrPend;

    assign idle = (state == axiIdle);

    // write needs both channels, and goes ahead of a read
    assign wrPend = awvalid && wvalid;

    assign reqValid = idle && (wrPend || arvalid);
    assign reqWrite = wrPend;
    assign reqId    = wrPend ? awaddr[14:3] : araddr[14:3];
    assign reqOp    = opWrite;
    assign reqData  = wdata;

    assign awready = idle && wrPend && grant;
    assign wready  = idle && wrPend && grant;
    assign arready = idle && !wrPend && grant;

    assign bvalid = (state == writeResp);
    assign rvalid = (state == readResp);
    assign bresp  = 2'b00;
    assign rresp  = 2'b00;
    assign rdata  = readQ;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= axiIdle;
        end else begin
            case (state)
                axiIdle: begin
                    if (awready) begin
                        state <= writeResp;
                    end else if (arready) begin
                        state <= readResp;
                    end
                end
                writeResp: if (bready) state <= axiIdle;
                readResp:  if (rready) state <= axiIdle;
                default:   state <= axiIdle;
            endcase
        end
    end

    // old value held for the R channel
    always_ff @(posedge clk) begin
        if (arready) begin
            readQ <= readData;
        end
    end

endmodule

// ==== csrFile.sv ====
module csrFile import csrPkg::*; #(
    parameter csrData resetVector = 64'h0000_0000_8000_0000
) (
    input  logic   clk,
    input  logic   arstN,
    input  logic   accValid,
    input  csrId   accId,
    input  csrOp   accOp,
    input  logic   accWrite,
    input  csrData accData,
    input  logic   ecall,
    input  csrData epc,
    input  logic   mret,
    output csrData accRdata,
    output csrData mtvec,
    output csrData mepc
);

    csrData mstatusQ;
    csrData mtvecQ;
    csrData mscratchQ;
    csrData mepcQ;
    csrData mcauseQ;

    csrData wrValue;
    csrData mstatusTrap;
    logic   wrEn;

    assign wrEn = accValid && accWrite;

    // old value, unknown numbers read as zero
    always_comb begin
        case (accId)
            idMstatus:  accRdata = mstatusQ;
            idMtvec:    accRdata = mtvecQ;
            idMscratch: accRdata = mscratchQ;
            idMepc:     accRdata = mepcQ;
            idMcause:   accRdata = mcauseQ;
            default:    accRdata = '0;
        endcase
    end

    // new value from op and old value
    always_comb begin
        case (accOp)
            opWrite: wrValue = accData;
            opSet:   wrValue = accRdata | accData;
            opClear: wrValue = accRdata & ~accData;
            default: wrValue = '0;
        endcase
    end

    // interrupt-enable stack on trap entry and return
    always_comb begin
        mstatusTrap = mstatusQ;
        if (ecall) begin
            mstatusTrap[bitMpie] = mstatusQ[bitMie];
            mstatusTrap[bitMie]  = 1'b0;
        end else if (mret) begin
            mstatusTrap[bitMie]  = mstatusQ[bitMpie];
            mstatusTrap[bitMpie] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mstatusQ <= mstatusReset;
        end else if (ecall || mret) begin
            mstatusQ <= mstatusTrap;
        end else if (wrEn && accId == idMstatus) begin
            mstatusQ <= wrValue;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mtvecQ    <= resetVector;
            mscratchQ <= '0;
        end else if (wrEn) begin
            if (accId == idMtvec) begin
                mtvecQ <= wrValue;
            end
            if (accId == idMscratch) begin
                mscratchQ <= wrValue;
            end
        end
    end

    // trap wins over a same-cycle write
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mepcQ   <= '0;
            mcauseQ <= '0;
        end else if (ecall) begin
            mepcQ   <= epc;
            mcauseQ <= causeEcall;
        end else if (wrEn) begin
            if (accId == idMepc) begin
                mepcQ <= wrValue;
            end
            if (accId == idMcause) begin
                mcauseQ <= wrValue;
            end
        end
    end

    assign mtvec = mtvecQ;
    assign mepc  = mepcQ;

endmodule

// ==== csrInstrPort.sv ====
module csrInstrPort import csrPkg::*; (
    input  logic   clk,
    input  logic   arstN,
    input  logic   cmdValid,
    input  csrId   cmdId,
    input  csrOp   cmdOp,
    input  csrData cmdData,
    input  logic   rspReady,
    input  logic   grant,
    input  csrData rdata,
    output logic   cmdReady,
    output logic   rspValid,
    output csrData rspData,
    output logic   reqValid,
    output csrId   reqId,
    output csrOp   reqOp,
    output logic   reqWrite,
    output csrData reqData
);

    portState state;
    csrData   oldValue;

    // requests only go out while no response is pending
    assign reqValid = (state == portIdle) && cmdValid;
    assign reqId    = cmdId;
    assign reqOp    = cmdOp;
    assign reqWrite = 1'b1;
    assign reqData  = cmdData;

    assign cmdReady = (state == portIdle) && grant;
    assign rspValid = (state == respond);
    assign rspData  = oldValue;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= portIdle;
        end else begin
            case (state)
                portIdle: if (cmdValid && grant) state <= respond;
                respond:  if (rspReady) state <= portIdle;
                default:  state <= portIdle;
            endcase
        end
    end

    // capture old value in the accepting cycle
    always_ff @(posedge clk) begin
        if (cmdReady && cmdValid) begin
            oldValue <= rdata;
        end
    end

endmodule

// ==== csrPkg.sv ====
package csrPkg;

    // value, register number and operation widths
    typedef logic [63:0] csrData;
    typedef logic [11:0] csrId;
    typedef logic [1:0]  csrOp;

    // host byte address, CSR number sits in bits 14..3
    typedef logic [14:0] axiAddr;

    // machine-mode CSR numbers
    localparam csrId idMstatus  = 12'h300;
    localparam csrId idMtvec    = 12'h305;
    localparam csrId idMscratch = 12'h340;
    localparam csrId idMepc     = 12'h341;
    localparam csrId idMcause   = 12'h342;

    // read-modify-write operations, code 2'b11 stores zero
    localparam csrOp opWrite = 2'b00;
    localparam csrOp opSet   = 2'b01;
    localparam csrOp opClear = 2'b10;

    // mstatus after reset, SXL/UXL and MPP fields preset
    localparam csrData mstatusReset = 64'h0000_000a_0000_1800;

    // environment call from machine mode
    localparam csrData causeEcall = 64'd11;

    // interrupt-enable bit positions in mstatus
    localparam int bitMie  = 3;
    localparam int bitMpie = 7;

    // host slave states
    typedef enum logic [1:0] {
        axiIdle,
        writeResp,
        readResp
    } axiState;

    // core command port states
    typedef enum logic {
        portIdle,
        respond
    } portState;

endpackage

// ==== csrSubsystem.sv ====
module csrSubsystem import csrPkg::*; #(
    parameter csrData resetVector = 64'h0000_0000_8000_0000
) (
    input  logic       clk,
    input  logic       arstN,
    // core command and response
    input  logic       cmdValid,
    output logic       cmdReady,
    input  csrId       cmdId,
    input  csrOp       cmdOp,
    input  csrData     cmdData,
    output logic       rspValid,
    output csrData     rspData,
    input  logic       rspReady,
    // traps
    input  logic       ecall,
    input  csrData     epc,
    input  logic       mret,
    // host AXI4-Lite
    input  logic       awvalid,
    output logic       awready,
    input  axiAddr     awaddr,
    input  logic       wvalid,
    output logic       wready,
    input  csrData     wdata,
    input  logic [7:0] wstrb,
    output logic       bvalid,
    input  logic       bready,
    output logic [1:0] bresp,
    input  logic       arvalid,
    output logic       arready,
    input  axiAddr     araddr,
    output logic       rvalid,
    input  logic       rready,
    output csrData     rdata,
    output logic [1:0] rresp,
    // redirect targets
    output csrData     mtvec,
    output csrData     mepc
);

    logic   instrValid;
    csrId   instrId;
    csrOp   instrOp;
    logic   instrWrite;
    csrData instrData;
    logic   instrGrant;

    logic   hostValid;
    csrId   hostId;
    csrOp   hostOp;
    logic   hostWrite;
    csrData hostData;
    logic   hostGrant;

    csrData arbRdata;
    logic   accValid;
    csrId   accId;
    csrOp   accOp;
    logic   accWrite;
    csrData accData;
    csrData accRdata;

    csrInstrPort instrPort_i (
        .clk      (clk),
        .arstN    (arstN),
        .cmdValid (cmdValid),
        .cmdId    (cmdId),
        .cmdOp    (cmdOp),
        .cmdData  (cmdData),
        .rspReady (rspReady),
        .grant    (instrGrant),
        .rdata    (arbRdata),
        .cmdReady (cmdReady),
        .rspValid (rspValid),
        .rspData  (rspData),
        .reqValid (instrValid),
        .reqId    (instrId),
        .reqOp    (instrOp),
        .reqWrite (instrWrite),
        .reqData  (instrData)
    );

    csrAxiLiteSlave hostPort_i (
        .clk      (clk),
        .arstN    (arstN),
        .awvalid  (awvalid),
        .awready  (awready),
        .awaddr   (awaddr),
        .wvalid   (wvalid),
        .wready   (wready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .bvalid   (bvalid),
        .bready   (bready),
        .bresp    (bresp),
        .arvalid  (arvalid),
        .arready  (arready),
        .araddr   (araddr),
        .rvalid   (rvalid),
        .rready   (rready),
        .rdata    (rdata),
        .rresp    (rresp),
        .grant    (hostGrant),
        .readData (arbRdata),
        .reqValid (hostValid),
        .reqId    (hostId),
        .reqOp    (hostOp),
        .reqWrite (hostWrite),
        .reqData  (hostData)
    );

    // requester 0 is the core, requester 1 the host
    csrArbiter arbiter_i (
        .clk      (clk),
        .arstN    (arstN),
        .valid0   (instrValid),
        .id0      (instrId),
        .op0      (instrOp),
        .write0   (instrWrite),
        .data0    (instrData),
        .valid1   (hostValid),
        .id1      (hostId),
        .op1      (hostOp),
        .write1   (hostWrite),
        .data1    (hostData),
        .accRdata (accRdata),
        .grant0   (instrGrant),
        .grant1   (hostGrant),
        .rdata    (arbRdata),
        .accValid (accValid),
        .accId    (accId),
        .accOp    (accOp),
        .accWrite (accWrite),
        .accData  (accData)
    );

    csrFile #(
        .resetVector (resetVector)
    ) csrFile_i (
        .clk      (clk),
        .arstN    (arstN),
        .accValid (accValid),
        .accId    (accId),
        .accOp    (accOp),
        .accWrite (accWrite),
        .accData  (accData),
        .ecall    (ecall),
        .epc      (epc),
        .mret     (mret),
        .accRdata (accRdata),
        .mtvec    (mtvec),
        .mepc     (mepc)
    );

endmodule

// ==== csrSubsystemTb.sv ====
module csrSubsystemTb;

    typedef enum logic [2:0] {
        kindCmd,
        kindHostWr,
        kindHostRd,
        kindEcall,
        kindMret,
        kindBoth
    } entryKind;

    typedef struct packed {
        entryKind    kind;
        logic [11:0] id;
        logic [1:0]  op;
        logic [63:0] data;
        logic [63:0] epc;
    } stimEntry;

    logic        clk;
    logic        arstN;
    logic        cmdValid, cmdReady, rspValid, rspReady;
    logic [11:0] cmdId;
    logic [1:0]  cmdOp;
    logic [63:0] cmdData, rspData;
    logic        ecall, mret;
    logic [63:0] epc, mtvec, mepc;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    logic [14:0] awaddr, araddr;
    logic [63:0] wdata, rdata;
    logic [7:0]  wstrb;
    logic [1:0]  bresp, rresp;

    stimEntry    stimTable[$];
    stimEntry    entry;
    logic [11:0] csrIds [0:4];
    logic [63:0] model [0:4];
    logic [63:0] expOld, gotCmd, gotHost;
    logic        tableReady;
    integer      seed;
    int          errors;
    int          checks;

    csrSubsystem #(
        .resetVector (64'h0000_0000_8000_0000)
    ) csrSubsystem_i (
        .clk (clk), .arstN (arstN),
        .cmdValid (cmdValid), .cmdReady (cmdReady), .cmdId (cmdId), .cmdOp (cmdOp),
        .cmdData (cmdData), .rspValid (rspValid), .rspData (rspData), .rspReady (rspReady),
        .ecall (ecall), .epc (epc), .mret (mret),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
        .wvalid (wvalid), .wready (wready), .wdata (wdata), .wstrb (wstrb),
        .bvalid (bvalid), .bready (bready), .bresp (bresp),
        .arvalid (arvalid), .arready (arready), .araddr (araddr),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp),
        .mtvec (mtvec), .mepc (mepc)
    );

    always #10 clk = ~clk;

    // ready about three cycles in four
    function automatic logic randomBit();
        randomBit = ($random(seed) & 3) != 0;
    endfunction

    function automatic int slotOf(input logic [11:0] id);
        case (id)
            12'h300: slotOf = 0;
            12'h305: slotOf = 1;
            12'h340: slotOf = 2;
            12'h341: slotOf = 3;
            12'h342: slotOf = 4;
            default: slotOf = -1;
        endcase
    endfunction

    function automatic logic [63:0] modelRead(input logic [11:0] id);
        int slot;
        slot = slotOf(id);
        modelRead = (slot < 0) ? 64'h0 : model[slot];
    endfunction

    // op code 3 stores zero
    task automatic modelApply(input logic [11:0] id, input logic [1:0] op,
                              input logic [63:0] data);
        int slot;
        logic [63:0] old;
        slot = slotOf(id);
        old = modelRead(id);
        if (slot >= 0) begin
            case (op)
                2'b00:   model[slot] = data;
                2'b01:   model[slot] = old | data;
                2'b10:   model[slot] = old & ~data;
                default: model[slot] = 64'h0;
            endcase
        end
    endtask

    task automatic checkValue(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkOneOf(input string name, input logic [63:0] got,
                              input logic [63:0] expA, input logic [63:0] expB);
        checks++;
        assert (got === expA || got === expB) else begin
            errors++;
            $display("mismatch %s: got %h, expected %h or %h", name, got, expA, expB);
        end
    endtask

    task automatic runCommand(input logic [11:0] id, input logic [1:0] op,
                              input logic [63:0] data, output logic [63:0] old);
        logic done;
        cmdValid <= 1'b1;
        cmdId    <= id;
        cmdOp    <= op;
        cmdData  <= data;
        @(posedge clk);
        while (!cmdReady) @(posedge clk);
        cmdValid <= 1'b0;
        done = 1'b0;
        while (!done) begin
            rspReady <= randomBit();
            @(posedge clk);
            if (rspValid && rspReady) begin
                done = 1'b1;
                old  = rspData;
            end
        end
        rspReady <= 1'b0;
    endtask

    task automatic hostWrite(input logic [11:0] id, input logic [63:0] data);
        logic done;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        awaddr  <= {id, 3'b000};
        wdata   <= data;
        wstrb   <= 8'hff;
        @(posedge clk);
        while (!awready) @(posedge clk);
        checks++;
        assert (wready) else begin
            errors++;
            $display("wready did not rise together with awready");
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        done = 1'b0;
        while (!done) begin
            bready <= randomBit();
            @(posedge clk);
            if (bvalid && bready) begin
                done = 1'b1;
                checkValue("bresp", {62'h0, bresp}, 64'h0);
            end
        end
        bready <= 1'b0;
    endtask

    // low address bits set so the slave has to drop them
    task automatic hostRead(input logic [11:0] id, output logic [63:0] value);
        logic done;
        arvalid <= 1'b1;
        araddr  <= {id, 3'b101};
        @(posedge clk);
        while (!arready) @(posedge clk);
        arvalid <= 1'b0;
        done = 1'b0;
        while (!done) begin
            rready <= randomBit();
            @(posedge clk);
            if (rvalid && rready) begin
                done  = 1'b1;
                value = rdata;
                checkValue("rresp", {62'h0, rresp}, 64'h0);
            end
        end
        rready <= 1'b0;
    endtask

    task automatic pulseTrap(input logic isEcall, input logic [63:0] pc);
        ecall <= isEcall;
        mret  <= !isEcall;
        epc   <= pc;
        @(posedge clk);
        ecall <= 1'b0;
        mret  <= 1'b0;
        @(posedge clk);
    endtask

    task automatic addEntry(input entryKind kind, input logic [11:0] id,
                            input logic [1:0] op, input logic [63:0] data,
                            input logic [63:0] pc);
        stimEntry e;
        e.kind = kind;
        e.id   = id;
        e.op   = op;
        e.data = data;
        e.epc  = pc;
        stimTable.push_back(e);
    endtask

    task automatic buildTable();
        csrIds[0] = 12'h300;
        csrIds[1] = 12'h305;
        csrIds[2] = 12'h340;
        csrIds[3] = 12'h341;
        csrIds[4] = 12'h342;
        // reset values
        for (int i = 0; i < 5; i++) addEntry(kindHostRd, csrIds[i], 2'b00, 64'h0, 64'h0);
        for (int i = 0; i < 5; i++) begin
            addEntry(kindCmd, csrIds[i], 2'b00, {4'ha, csrIds[i], 48'h5a5a_0000_c3c3}, 64'h0);
            addEntry(kindCmd, csrIds[i], 2'b01, 64'h00f0_0000_0000_0f0f, 64'h0);
            addEntry(kindCmd, csrIds[i], 2'b10, 64'h0f00_00ff_0000_00f0, 64'h0);
            addEntry(kindHostRd, csrIds[i], 2'b00, 64'h0, 64'h0);
        end
        addEntry(kindCmd, 12'h340, 2'b11, 64'hffff, 64'h0);
        addEntry(kindHostRd, 12'h340, 2'b00, 64'h0, 64'h0);
        // host writes read back from both sides
        addEntry(kindHostWr, 12'h340, 2'b00, 64'hcafe_f00d_1234_5678, 64'h0);
        addEntry(kindHostRd, 12'h340, 2'b00, 64'h0, 64'h0);
        addEntry(kindCmd, 12'h340, 2'b01, 64'h1, 64'h0);
        addEntry(kindHostWr, 12'h305, 2'b00, 64'h8000_0100, 64'h0);
        addEntry(kindHostRd, 12'h305, 2'b00, 64'h0, 64'h0);
        // unknown number
        addEntry(kindHostWr, 12'h7c0, 2'b00, 64'h1111_2222, 64'h0);
        addEntry(kindHostRd, 12'h7c0, 2'b00, 64'h0, 64'h0);
        addEntry(kindCmd, 12'h7c0, 2'b00, 64'h3333, 64'h0);
        addEntry(kindHostRd, 12'h7c0, 2'b00, 64'h0, 64'h0);
        // MIE set and MPIE clear before the trap
        addEntry(kindCmd, 12'h300, 2'b00, 64'ha_0000_1808, 64'h0);
        addEntry(kindEcall, 12'h0, 2'b00, 64'h0, 64'h8000_2468);
        addEntry(kindHostRd, 12'h341, 2'b00, 64'h0, 64'h0);
        addEntry(kindHostRd, 12'h342, 2'b00, 64'h0, 64'h0);
        addEntry(kindHostRd, 12'h300, 2'b00, 64'h0, 64'h0);
        addEntry(kindMret, 12'h0, 2'b00, 64'h0, 64'h0);
        addEntry(kindHostRd, 12'h300, 2'b00, 64'h0, 64'h0);
        addEntry(kindEcall, 12'h0, 2'b00, 64'h0, 64'h8000_3000);
        // MPIE cleared so the return has to set it
        addEntry(kindCmd, 12'h300, 2'b10, 64'h80, 64'h0);
        addEntry(kindMret, 12'h0, 2'b00, 64'h0, 64'h0);
        addEntry(kindCmd, 12'h300, 2'b01, 64'h0, 64'h0);
        // both ports on disjoint bits of mscratch
        addEntry(kindHostWr, 12'h340, 2'b00, 64'h1234_5678_9abc_def0, 64'h0);
        addEntry(kindBoth, 12'h340, 2'b01, 64'h0000_0000_0000_000f, 64'h0);
        addEntry(kindBoth, 12'h340, 2'b10, 64'hf000_0000_0000_0000, 64'h0);
        addEntry(kindBoth, 12'h340, 2'b10, 64'h0000_0000_00f0_0000, 64'h0);
        addEntry(kindBoth, 12'h340, 2'b01, 64'h0f00_0000_0000_0000, 64'h0);
        addEntry(kindHostRd, 12'h340, 2'b00, 64'h0, 64'h0);
    endtask

    initial begin
        tableReady = 1'b0;
        wait (tableReady);
        repeat (stimTable.size() * 60 + 10) @(posedge clk);
        $display("timeout: the stimulus table did not complete in time");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        seed = 32'hb1d0;
        errors = 0;
        checks = 0;
        clk = 1'b0;
        arstN = 1'b0;
        {cmdValid, rspReady, ecall, mret} = 4'b0;
        {awvalid, wvalid, bready, arvalid, rready} = 5'b0;
        cmdId = 12'h0;
        cmdOp = 2'b00;
        cmdData = 64'h0;
        epc = 64'h0;
        awaddr = 15'h0;
        araddr = 15'h0;
        wdata = 64'h0;
        wstrb = 8'h0;
        model[0] = 64'ha_0000_1800;
        model[1] = 64'h8000_0000;
        model[2] = 64'h0;
        model[3] = 64'h0;
        model[4] = 64'h0;
        buildTable();
        tableReady = 1'b1;
        repeat (3) @(posedge clk);
        arstN <= 1'b1;
        @(posedge clk);
        checkValue("mtvec", mtvec, 64'h8000_0000);
        foreach (stimTable[i]) begin
            entry = stimTable[i];
            case (entry.kind)
                kindCmd: begin
                    expOld = modelRead(entry.id);
                    runCommand(entry.id, entry.op, entry.data, gotCmd);
                    checkValue("rspData", gotCmd, expOld);
                    modelApply(entry.id, entry.op, entry.data);
                end
                kindHostWr: begin
                    hostWrite(entry.id, entry.data);
                    modelApply(entry.id, 2'b00, entry.data);
                end
                kindHostRd: begin
                    hostRead(entry.id, gotHost);
                    checkValue("rdata", gotHost, modelRead(entry.id));
                end
                kindEcall: begin
                    pulseTrap(1'b1, entry.epc);
                    model[3] = entry.epc;
                    model[4] = 64'd11;
                    model[0][7] = model[0][3];
                    model[0][3] = 1'b0;
                end
                kindMret: begin
                    pulseTrap(1'b0, 64'h0);
                    model[0][3] = model[0][7];
                    model[0][7] = 1'b1;
                end
                default: begin
                    // host read may land before or after the core's update
                    expOld = modelRead(entry.id);
                    fork
                        runCommand(entry.id, entry.op, entry.data, gotCmd);
                        hostRead(entry.id, gotHost);
                    join
                    checkValue("rspData", gotCmd, expOld);
                    modelApply(entry.id, entry.op, entry.data);
                    checkOneOf("rdata", gotHost, expOld, modelRead(entry.id));
                end
            endcase
            checkValue("mtvec", mtvec, modelRead(12'h305));
            checkValue("mepc", mepc, modelRead(12'h341));
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f build.f \
    --top-module csrSubsystemTb \
    -Mdir obj_dir \
    -o csrSubsystemSim

./obj_dir/csrSubsystemSim | tee sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
